//--- verilog/lock_key_pkg.sv
`default_nettype none

package lock_key_pkg;

    // what a key does
    typedef enum logic [2:0] {
        KEY_DIGIT = 3'd0,
        KEY_ENTER = 3'd1,
        KEY_BACK  = 3'd2,
        KEY_CLEAR = 3'd3,
        KEY_SET   = 3'd4
    } key_kind_e;

    typedef struct packed {
        key_kind_e  kind;
        logic [3:0] digit;   // 0-9, digits only
    } key_event_t;

    // one-hot positions of the command keys
    localparam int KEY_ENTER_BIT = 0;
    localparam int KEY_SET_BIT   = 4;
    localparam int KEY_CLEAR_BIT = 8;
    localparam int KEY_BACK_BIT  = 12;

    localparam logic [3:0] DIGIT_BLANK = 4'hF;
    localparam logic [3:0] MSG_MARKER  = 4'hB;   // never a digit value

    // digit code per keypad bit, bit 15 first; blank where no digit sits
    localparam logic [15:0][3:0] DIGIT_MAP = {
        4'h7, 4'h8, 4'h9, DIGIT_BLANK,
        4'h4, 4'h5, 4'h6, DIGIT_BLANK,
        4'h1, 4'h2, 4'h3, DIGIT_BLANK,
        4'h0, DIGIT_BLANK, DIGIT_BLANK, DIGIT_BLANK
    };

    localparam logic [7:0] MSG_PASS = 8'hCC;
    localparam logic [7:0] MSG_SET  = 8'hDD;

    typedef struct packed {
        logic [3:0] hi;
        logic [3:0] mid;
        logic [3:0] lo;
    } digits_view_t;

    typedef struct packed {
        logic [3:0] marker;
        logic [7:0] msg_id;
    } msg_view_t;

    // same 12 bits seen as digits or as a message
    typedef union packed {
        digits_view_t digits;
        msg_view_t    msg;
    } lock_display_u;

    localparam logic [11:0] DISPLAY_BLANK = {3{DIGIT_BLANK}};
    localparam logic [11:0] DEFAULT_CODE  = 12'h246;

endpackage

`default_nettype wire

//--- verilog/lock_timing_pkg.sv
`default_nettype none

package lock_timing_pkg;

    typedef enum logic [1:0] {
        TONE_CLICK   = 2'd0,
        TONE_SUCCESS = 2'd1,
        TONE_FAIL    = 2'd2,
        TONE_TICK    = 2'd3
    } tone_kind_e;

    typedef struct packed {
        logic       valid;
        tone_kind_e kind;
    } tone_req_t;

    localparam int TONE_CNT_W = 8;

    // indexed by tone kind, tick first
    localparam logic [3:0][TONE_CNT_W-1:0] TONE_HALF_PERIOD = {8'd4, 8'd5, 8'd2, 8'd3};
    localparam logic [3:0][TONE_CNT_W-1:0] TONE_DURATION    = {8'd16, 8'd50, 8'd40, 8'd24};

    // lockout countdown, scaled down
    localparam int         TICK_CYCLES   = 32;
    localparam int         TICK_CNT_W    = $clog2(TICK_CYCLES);
    localparam logic [7:0] LOCKOUT_START = 8'h20;   // bcd
    localparam int         MAX_TRIES     = 3;

endpackage

`default_nettype wire

//--- verilog/key_decoder.sv
`timescale 1ns/10ps
`default_nettype none

module key_decoder (
    input  wire                       clk,
    input  wire                       rst,
    input  wire  [15:0]               keys,
    output logic                      key_req,
    output lock_key_pkg::key_event_t  key_ev,
    input  wire                       key_ack
);
    import lock_key_pkg::*;

    logic [15:0] prev_keys;
    logic [3:0]  hit_idx;
    logic        mapped;
    logic        press;
    key_event_t  new_ev;

    always_comb begin
        hit_idx = '0;
        for (int i = 0; i < 16; i++) begin
            if (keys[i]) begin
                hit_idx = 4'(i);
            end
        end
    end

    always_comb begin
        new_ev.kind  = KEY_DIGIT;
        new_ev.digit = DIGIT_MAP[hit_idx];
        mapped       = 1'b1;
        case (hit_idx)
            4'(KEY_ENTER_BIT): new_ev.kind = KEY_ENTER;
            4'(KEY_SET_BIT):   new_ev.kind = KEY_SET;
            4'(KEY_CLEAR_BIT): new_ev.kind = KEY_CLEAR;
            4'(KEY_BACK_BIT):  new_ev.kind = KEY_BACK;
            default:           mapped = (DIGIT_MAP[hit_idx] != DIGIT_BLANK);   // bits 1, 2
        endcase
    end

    // idle to single mapped key
    assign press = (prev_keys == '0) && $onehot(keys) && mapped;

    always_ff @(posedge clk) begin
        if (rst) begin
            prev_keys <= '0;
            key_req   <= 1'b0;
        end else begin
            prev_keys <= keys;
            if (key_req && key_ack) begin
                key_req <= 1'b0;
            end else if (press && !key_req && !key_ack) begin
                key_req <= 1'b1;   // press during open handshake is dropped
            end
        end
    end

    always_ff @(posedge clk) begin
        if (press && !key_req && !key_ack) begin
            key_ev <= new_ev;
        end
    end

    a_req_held: assert property (@(posedge clk) disable iff (rst)
        (key_req && !key_ack) |=> (key_req && $stable(key_ev)));

endmodule

`default_nettype wire

//--- verilog/entry_controller.sv
`timescale 1ns/10ps
`default_nettype none

module entry_controller (
    input  wire                          clk,
    input  wire                          rst,
    input  wire                          key_req,
    input  wire lock_key_pkg::key_event_t key_ev,
    output logic                         key_ack,
    output lock_key_pkg::lock_display_u  display,
    output logic                         unlocked,
    output logic                         locked_out,
    output lock_timing_pkg::tone_req_t   tone
);
    import lock_key_pkg::*;
    import lock_timing_pkg::*;

    logic [11:0]           stored_code;
    logic [1:0]            digit_cnt;    // digits on display
    logic [1:0]            tries;
    logic                  set_mode;
    logic [7:0]            countdown;    // bcd
    logic [TICK_CNT_W-1:0] tick_cnt;
    logic                  take;         // key taken this cycle
    logic                  tick_end;
    logic [3:0]            next_hi;
    logic [3:0]            next_mid;
    logic [7:0]            next_count;

    assign take     = key_req && !key_ack;
    assign tick_end = locked_out && (tick_cnt == TICK_CNT_W'(TICK_CYCLES - 1));

    // blank fill when fewer digits are on display, also clears a message
    assign next_hi  = (digit_cnt >= 2'd2) ? display.digits.mid : DIGIT_BLANK;
    assign next_mid = (digit_cnt >= 2'd1) ? display.digits.lo : DIGIT_BLANK;

    // bcd step down
    assign next_count = (countdown[3:0] == 4'd0) ? {countdown[7:4] - 4'd1, 4'd9}
                                                 : {countdown[7:4], countdown[3:0] - 4'd1};

    always_ff @(posedge clk) begin
        if (rst) begin
            key_ack     <= 1'b0;
            display     <= DISPLAY_BLANK;
            unlocked    <= 1'b0;
            locked_out  <= 1'b0;
            tone        <= '0;
            stored_code <= DEFAULT_CODE;
            digit_cnt   <= 2'd0;
            tries       <= 2'd0;
            set_mode    <= 1'b0;
            countdown   <= 8'h00;
            tick_cnt    <= '0;
        end else begin
            tone.valid <= 1'b0;
            if (take) begin
                key_ack <= 1'b1;
            end else if (!key_req) begin
                key_ack <= 1'b0;
            end

            if (locked_out) begin
                // keys are acked above and discarded here
                tick_cnt <= tick_end ? '0 : tick_cnt + 1'b1;
                if (tick_end) begin
                    if (countdown == 8'h00) begin
                        locked_out <= 1'b0;
                        display    <= DISPLAY_BLANK;
                    end else begin
                        countdown <= next_count;
                        display   <= {DIGIT_BLANK, next_count};
                        tone      <= '{valid: 1'b1, kind: TONE_TICK};
                    end
                end
            end else if (take && key_ev.kind == KEY_CLEAR) begin
                display   <= DISPLAY_BLANK;
                digit_cnt <= 2'd0;
                tries     <= 2'd0;
                set_mode  <= 1'b0;
                unlocked  <= 1'b0;
            end else if (take && !unlocked) begin
                case (key_ev.kind)
                    KEY_DIGIT: begin
                        if (digit_cnt != 2'd3) begin
                            display   <= {next_hi, next_mid, key_ev.digit};
                            digit_cnt <= digit_cnt + 2'd1;
                            tone      <= '{valid: 1'b1, kind: TONE_CLICK};
                        end
                    end
                    KEY_BACK: begin
                        if (digit_cnt != 2'd0) begin
                            display   <= {DIGIT_BLANK, display.digits.hi, display.digits.mid};
                            digit_cnt <= digit_cnt - 2'd1;
                            tone      <= '{valid: 1'b1, kind: TONE_CLICK};
                        end
                    end
                    KEY_ENTER: begin
                        if (digit_cnt == 2'd3) begin
                            digit_cnt <= 2'd0;
                            if (set_mode) begin
                                stored_code <= display.digits;
                                set_mode    <= 1'b0;
                                tries       <= 2'd0;
                                display     <= DISPLAY_BLANK;
                                tone        <= '{valid: 1'b1, kind: TONE_SUCCESS};
                            end else if (display.digits == stored_code) begin
                                display  <= {MSG_MARKER, MSG_PASS};
                                unlocked <= 1'b1;
                                tone     <= '{valid: 1'b1, kind: TONE_SUCCESS};
                            end else begin
                                tone <= '{valid: 1'b1, kind: TONE_FAIL};
                                if (tries == 2'(MAX_TRIES - 1)) begin
                                    tries      <= 2'd0;
                                    locked_out <= 1'b1;
                                    countdown  <= LOCKOUT_START;
                                    tick_cnt   <= '0;
                                    display    <= {DIGIT_BLANK, LOCKOUT_START};
                                end else begin
                                    tries   <= tries + 2'd1;
                                    display <= DISPLAY_BLANK;
                                end
                            end
                        end
                    end
                    KEY_SET: begin
                        display   <= {MSG_MARKER, MSG_SET};
                        set_mode  <= 1'b1;
                        digit_cnt <= 2'd0;
                    end
                    default: ;
                endcase
            end
        end
    end

    a_ack_needs_req: assert property (@(posedge clk) disable iff (rst)
        $rose(key_ack) |-> key_req);

    // a key taken in lockout leaves the entry state alone
    a_lockout_discards: assert property (@(posedge clk) disable iff (rst)
        (locked_out && take) |=> ($stable(stored_code) && $stable(set_mode)
                                  && $stable(unlocked) && $stable(digit_cnt)));

endmodule

`default_nettype wire

//--- verilog/tone_generator.sv
`timescale 1ns/10ps
`default_nettype none

module tone_generator (
    input  wire                        clk,
    input  wire                        rst,
    input  wire lock_timing_pkg::tone_req_t tone,
    output logic                       buzzer
);
    import lock_timing_pkg::*;

    tone_kind_e            kind;
    logic                  active;
    logic [TONE_CNT_W-1:0] dur_cnt;      // cycles since start
    logic [TONE_CNT_W-1:0] half_cnt;
    logic [TONE_CNT_W-1:0] half_period;
    logic [TONE_CNT_W-1:0] duration;

    assign half_period = TONE_HALF_PERIOD[kind];
    assign duration    = TONE_DURATION[kind];

    always_ff @(posedge clk) begin
        if (tone.valid) begin
            kind <= tone.kind;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            active   <= 1'b0;
            buzzer   <= 1'b0;
            dur_cnt  <= '0;
            half_cnt <= '0;
        end else if (tone.valid) begin
            // newer tone restarts the pattern
            active   <= 1'b1;
            buzzer   <= 1'b1;
            dur_cnt  <= '0;
            half_cnt <= '0;
        end else if (active) begin
            if (dur_cnt == duration - 1'b1) begin
                active <= 1'b0;
                buzzer <= 1'b0;
            end else begin
                dur_cnt <= dur_cnt + 1'b1;
                if (half_cnt == half_period - 1'b1) begin
                    half_cnt <= '0;
                    buzzer   <= ~buzzer;
                end else begin
                    half_cnt <= half_cnt + 1'b1;
                end
            end
        end
    end

    a_quiet_when_idle: assert property (@(posedge clk) disable iff (rst)
        !active |-> !buzzer);

endmodule

`default_nettype wire

//--- verilog/code_lock_top.sv
`timescale 1ns/10ps
`default_nettype none

module code_lock_top (
    input  wire                         clk,
    input  wire                         rst,
    input  wire  [15:0]                 keys,
    output lock_key_pkg::lock_display_u display,
    output logic                        unlocked,
    output logic                        locked_out,
    output logic                        buzzer
);
    import lock_key_pkg::*;
    import lock_timing_pkg::*;

    logic       key_req;
    logic       key_ack;
    key_event_t key_ev;
    tone_req_t  tone;   // one-cycle pulse

    key_decoder i_key_decoder (
        .clk     (clk),
        .rst     (rst),
        .keys    (keys),
        .key_req (key_req),
        .key_ev  (key_ev),
        .key_ack (key_ack)
    );

    entry_controller i_entry_controller (
        .clk        (clk),
        .rst        (rst),
        .key_req    (key_req),
        .key_ev     (key_ev),
        .key_ack    (key_ack),
        .display    (display),
        .unlocked   (unlocked),
        .locked_out (locked_out),
        .tone       (tone)
    );

    tone_generator i_tone_generator (
        .clk    (clk),
        .rst    (rst),
        .tone   (tone),
        .buzzer (buzzer)
    );

endmodule

`default_nettype wire

//--- verif/code_lock_tb.sv
`timescale 1ns/10ps
`default_nettype none

module code_lock_tb;
    import lock_key_pkg::*;

    localparam int BIT_ENTER      = 0;
    localparam int BIT_SET        = 4;
    localparam int BIT_CLEAR      = 8;
    localparam int BIT_BACK       = 12;
    localparam int LOCKOUT_CYCLES = 21 * 32;   // 20 down to 00, then blank
    localparam int PRESS_BUDGET   = 160;       // 9 cycles per press
    localparam int CYCLE_LIMIT    = PRESS_BUDGET * 9 + LOCKOUT_CYCLES + 1000;

    int digit_bit [10] = '{3, 7, 6, 5, 11, 10, 9, 15, 14, 13};   // keypad bit per digit

    logic          clk = 1'b0;
    logic          rst;
    logic [15:0]   keys;
    lock_display_u display;
    logic          unlocked;
    logic          locked_out;
    logic          buzzer;

    int          cycle = 0;
    int          buzz_edges = 0;
    logic        buzz_prev = 1'b0;
    logic [31:0] lfsr = 32'd98703;

    // reference model
    logic [11:0] m_disp;
    logic [3:0]  m_q[$];     // entered digits, oldest first
    logic [11:0] m_code;
    int          m_tries;
    logic        m_set;
    logic        m_unlocked;
    logic        m_locked;

    int   errors = 0;
    int   test_errs = 0;
    int   tests_run = 0;
    int   tests_failed = 0;
    int   checks = 0;
    int   tick_edges = -1;
    logic buzz_after_reset;

    code_lock_top i_code_lock_top (
        .clk        (clk),
        .rst        (rst),
        .keys       (keys),
        .display    (display),
        .unlocked   (unlocked),
        .locked_out (locked_out),
        .buzzer     (buzzer)
    );

    always #2 clk = ~clk;

    always @(posedge clk) begin
        cycle <= cycle + 1;
    end

    always @(negedge clk) begin
        if (buzzer && !buzz_prev) begin
            buzz_edges <= buzz_edges + 1;
        end
        buzz_prev <= buzzer;
    end

    initial begin : watchdog
        wait (cycle >= CYCLE_LIMIT);
        $display("timeout: the run did not finish within %0d cycles", CYCLE_LIMIT);
        $display("CHECKS FAILED");
        $finish;
    end

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    task automatic rand_bits(input int n, output int val);
        val = 0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_next(lfsr);
            val  = (val << 1) | int'(lfsr[0]);
        end
    endtask

    task automatic rand_digit(output int d);
        int v;
        rand_bits(4, v);
        d = v % 10;
    endtask

    // any mapped key, commands on the top six values
    task automatic random_key(output int b);
        int v;
        rand_bits(4, v);
        if (v < 10) begin
            b = digit_bit[v];
        end else begin
            case ((v - 10) % 4)
                0:       b = BIT_ENTER;
                1:       b = BIT_SET;
                2:       b = BIT_CLEAR;
                default: b = BIT_BACK;
            endcase
        end
    endtask

    task automatic random_code(input logic [11:0] avoid, output logic [11:0] c);
        int d;
        for (int i = 2; i >= 0; i--) begin
            rand_digit(d);
            c[4*i +: 4] = 4'(d);
        end
        if (c == avoid) begin
            c[3:0] = (c[3:0] == 4'd9) ? 4'd0 : c[3:0] + 4'd1;
        end
    endtask

    function automatic logic [11:0] bcd_dec(input logic [7:0] b);
        int v;
        v = int'(b[7:4]) * 10 + int'(b[3:0]) - 1;
        return {4'hF, 4'(v / 10), 4'(v % 10)};
    endfunction

    // digits right aligned, blank on the left
    function automatic logic [11:0] digits_display();
        logic [11:0] d;
        int          n;
        d = 12'hFFF;
        n = m_q.size();
        for (int i = 0; i < n; i++) begin
            d[4*i +: 4] = m_q[n-1-i];
        end
        return d;
    endfunction

    task automatic model_key(input int b);
        logic [11:0] code;
        int          d;
        d = -1;
        for (int i = 0; i < 10; i++) begin
            if (digit_bit[i] == b) begin
                d = i;
            end
        end
        if (m_locked) begin
            return;   // lockout eats every key
        end
        if (b == BIT_CLEAR) begin
            m_disp = 12'hFFF;
            m_q.delete();
            m_tries    = 0;
            m_set      = 1'b0;
            m_unlocked = 1'b0;
        end else if (m_unlocked) begin
            return;
        end else if (d >= 0) begin
            if (m_q.size() < 3) begin
                m_q.push_back(4'(d));
                m_disp = digits_display();
            end
        end else if (b == BIT_BACK) begin
            if (m_q.size() > 0) begin
                void'(m_q.pop_back());
                m_disp = digits_display();
            end
        end else if (b == BIT_SET) begin
            m_disp = {MSG_MARKER, MSG_SET};
            m_set  = 1'b1;
            m_q.delete();
        end else if (b == BIT_ENTER && m_q.size() == 3) begin
            code = {m_q[0], m_q[1], m_q[2]};
            m_q.delete();
            if (m_set) begin
                m_code  = code;
                m_set   = 1'b0;
                m_tries = 0;
                m_disp  = 12'hFFF;
            end else if (code == m_code) begin
                m_disp     = {MSG_MARKER, MSG_PASS};
                m_unlocked = 1'b1;
            end else if (m_tries == 2) begin
                m_tries  = 0;
                m_locked = 1'b1;
                m_disp   = 12'hF20;
            end else begin
                m_tries++;
                m_disp = 12'hFFF;
            end
        end
    endtask

    task automatic step_cycles(input int n);
        repeat (n) begin
            @(posedge clk);
            #1;
        end
    endtask

    task automatic drive_keys(input logic [15:0] pattern, input int hold);
        keys = pattern;
        step_cycles(hold);
        keys = '0;
        step_cycles(6);
    endtask

    task automatic press(input int b);
        model_key(b);
        drive_keys(16'd1 << b, 3);
    endtask

    task automatic check_state(input string what);
        checks++;
        assert (display == m_disp && unlocked == m_unlocked && locked_out == m_locked) else begin
            $display({"MISMATCH at %0t: %s, display %h exp %h, ",
                      "unlocked %b exp %b, locked_out %b exp %b"},
                     $time, what, display, m_disp, unlocked, m_unlocked, locked_out, m_locked);
            test_errs++;
        end
    endtask

    task automatic check_value(input string what, input int got, input int exp);
        checks++;
        assert (got == exp) else begin
            $display("MISMATCH at %0t: %s, got %0d expected %0d", $time, what, got, exp);
            test_errs++;
        end
    endtask

    task automatic enter_code(input logic [11:0] c, input string what);
        for (int i = 2; i >= 0; i--) begin
            press(digit_bit[int'(c[4*i +: 4])]);
            check_state(what);
        end
    endtask

    task automatic wait_quiet();
        int low_run;
        low_run = 0;
        while (low_run < 12) begin   // longer than any half period
            step_cycles(1);
            low_run = buzzer ? 0 : low_run + 1;
        end
    endtask

    task automatic finish_test(input string name);
        tests_run++;
        errors += test_errs;
        if (test_errs == 0) begin
            $display("test %0d %s: ok", tests_run, name);
        end else begin
            $display("test %0d %s: %0d errors", tests_run, name, test_errs);
            tests_failed++;
        end
        test_errs = 0;
    endtask

    initial begin : stimulus
        logic [11:0] code;
        logic [11:0] last_disp;
        int          v;
        int          d;
        int          b;
        int          n;
        int          snap;
        int          last_cycle;
        keys       = '0;
        rst        = 1'b1;
        m_disp     = 12'hFFF;
        m_code     = 12'h246;
        m_tries    = 0;
        m_set      = 1'b0;
        m_unlocked = 1'b0;
        m_locked   = 1'b0;
        snap       = 0;
        last_cycle = 0;
        repeat (4) @(posedge clk);
        #1;
        rst = 1'b0;
        buzz_after_reset = buzzer;
        step_cycles(2);

        for (int i = 0; i < 40; i++) begin
            rand_bits(2, v);
            if (v == 0) begin
                press(BIT_BACK);
            end else begin
                rand_digit(d);
                press(digit_bit[d]);
            end
            check_state("random digit entry");
        end
        press(BIT_CLEAR);
        check_state("clear after entry");
        for (int i = 0; i < 4; i++) begin   // the fourth one is dropped
            rand_digit(d);
            press(digit_bit[d]);
            check_state("four digits in a row");
        end
        press(BIT_CLEAR);
        check_state("clear after four digits");
        finish_test("digit entry with back");

        enter_code(12'h246, "default code digits");
        press(BIT_ENTER);
        check_state("enter default code");
        for (int i = 0; i < 5; i++) begin
            random_key(b);
            press((b == BIT_CLEAR) ? BIT_SET : b);
            check_state("key while unlocked");
        end
        press(BIT_CLEAR);
        check_state("clear while unlocked");
        finish_test("correct code");

        for (int t = 0; t < 3; t++) begin
            random_code(m_code, code);
            enter_code(code, "wrong code digits");
            press(BIT_ENTER);
            check_state((t < 2) ? "wrong code" : "third wrong code");
        end
        for (int s = 1; s <= 21; s++) begin
            last_disp = display;
            n = 0;
            while (display == last_disp && n < 40) begin
                step_cycles(1);
                n++;
            end
            assert (n < 40) else begin
                $display("lockout countdown did not move on from %h", last_disp);
                test_errs++;
            end
            if (s < 21) begin
                m_disp = bcd_dec(m_disp[7:0]);
            end else begin
                m_locked = 1'b0;
                m_disp   = 12'hFFF;
            end
            check_state("lockout step");
            if (s > 1) begin
                check_value("lockout step length", cycle - last_cycle, 32);
            end
            last_cycle = cycle;
            if (s == 3) begin
                snap = buzz_edges;   // tick tone starts next edge
            end
            if (s == 4) begin
                tick_edges = buzz_edges - snap;
            end
            if (s < 20 && s % 2 == 1) begin
                random_key(b);
                press(b);
                check_state("key during lockout");
            end
        end
        press(BIT_CLEAR);
        check_state("clear after lockout");
        finish_test("wrong codes and lockout");

        press(BIT_SET);
        check_state("set key");
        random_code(m_code, code);
        enter_code(code, "new code digits");
        press(BIT_ENTER);
        check_state("store new code");
        enter_code(12'h246, "old code digits");
        press(BIT_ENTER);
        check_state("old code after change");
        enter_code(code, "new code again");
        press(BIT_ENTER);
        check_state("new code accepted");
        press(BIT_CLEAR);
        check_state("clear after new code");
        finish_test("set new code");

        check_value("buzzer after reset", int'(buzz_after_reset), 0);
        // edges = duration / (2 * half period)
        wait_quiet();
        snap = buzz_edges;
        rand_digit(d);
        press(digit_bit[d]);
        check_state("digit for click");
        wait_quiet();
        check_value("click edges", buzz_edges - snap, 4);
        press(BIT_CLEAR);
        enter_code(m_code, "code for success");
        wait_quiet();
        snap = buzz_edges;
        press(BIT_ENTER);
        check_state("success tone enter");
        wait_quiet();
        check_value("success edges", buzz_edges - snap, 10);
        press(BIT_CLEAR);
        random_code(m_code, code);
        enter_code(code, "code for fail");
        wait_quiet();
        snap = buzz_edges;
        press(BIT_ENTER);
        check_state("fail tone enter");
        wait_quiet();
        check_value("fail edges", buzz_edges - snap, 5);
        press(BIT_CLEAR);
        check_state("clear after tones");
        check_value("lockout tick edges", tick_edges, 2);
        finish_test("buzzer patterns");

        rand_digit(d);
        model_key(digit_bit[d]);
        drive_keys(16'd1 << digit_bit[d], 20);
        check_state("held key");
        drive_keys((16'd1 << digit_bit[1]) | (16'd1 << digit_bit[2]), 3);
        check_state("two keys at once");
        drive_keys(16'h0002, 3);
        check_state("unused bit 1");
        drive_keys(16'h0004, 3);
        check_state("unused bit 2");
        press(BIT_CLEAR);
        check_state("final clear");
        finish_test("key decoding rules");

        $display("%0d tests run, %0d failed, %0d checks, %0d errors",
                 tests_run, tests_failed, checks, errors);
        if (errors == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- build.f
verilog/lock_key_pkg.sv
verilog/lock_timing_pkg.sv
verilog/key_decoder.sv
verilog/entry_controller.sv
verilog/tone_generator.sv
verilog/code_lock_top.sv
verif/code_lock_tb.sv

//--- Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert
TOP       ?= code_lock_tb
BUILD_DIR ?= obj_dir
FILELIST  ?= build.f
LOG       ?= sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench, check $(LOG)"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "variables: VERILATOR VFLAGS TOP BUILD_DIR FILELIST LOG"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "ALL CHECKS PASSED" $(LOG) || (echo "simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
